//--- src/fabric_pkg.sv
//################################################
// Shared widths, address map and types of the command fabric
// Only local addresses below DRAM_BASE can reach a device
//################################################
package fabric_pkg;

  // Requester side
  localparam int NUM_SRC  = 2;
  localparam int SRC_ID_W = 1;

  // Command payload
  localparam int ADDR_W = 32;
  localparam int DATA_W = 64;

  // Local address fields
  localparam int TILE_MSB = 29;
  localparam int TILE_LSB = 22;
  localparam int DEV_MSB  = 21;
  localparam int DEV_LSB  = 18;
  localparam int REG_MSB  = 5;
  localparam int REG_LSB  = 3;

  typedef logic [ADDR_W-1:0]            addr_t;
  typedef logic [DATA_W-1:0]            data_t;
  typedef logic [TILE_MSB-TILE_LSB:0]   core_id_t;
  typedef logic [REG_MSB-REG_LSB:0]     reg_idx_t;
  typedef logic [SRC_ID_W-1:0]          src_id_t;

  // Anything at or above this is DRAM, host or another core
  localparam addr_t DRAM_BASE = 32'h8000_0000;

  // Device field codes
  localparam logic [DEV_MSB-DEV_LSB:0] DEV_ID_CLINT = 4'd1;
  localparam logic [DEV_MSB-DEV_LSB:0] DEV_ID_CFG   = 4'd2;

  // Configuration registers, 8 bytes apart
  localparam reg_idx_t CFG_REG_SCRATCH = 3'd0;
  localparam reg_idx_t CFG_REG_FREEZE  = 3'd1;
  localparam reg_idx_t CFG_REG_CORE_ID = 3'd2;

  // Core-local interrupt registers
  localparam reg_idx_t CLINT_REG_MTIME    = 3'd0;
  localparam reg_idx_t CLINT_REG_MTIMECMP = 3'd1;
  localparam reg_idx_t CLINT_REG_MSIP     = 3'd2;

  typedef enum logic [1:0]
  {
    DEV_CFG      = 2'd0,
    DEV_CLINT    = 2'd1,
    DEV_LOOPBACK = 2'd2
  } dev_e;

  // One transaction at a time
  typedef enum logic [1:0]
  {
    ST_IDLE   = 2'd0,
    ST_ACCESS = 2'd1,
    ST_RESP   = 2'd2
  } fabric_state_e;

endpackage

//--- src/dev_decode.sv
//################################################
// Address to device decode, purely combinational
// Other tiles and unmapped devices fall to loopback
//################################################
`timescale 1ns/100ps

module dev_decode
  (input  fabric_pkg::addr_t       req_addr_i
   , input  fabric_pkg::core_id_t  core_id_i
   , output fabric_pkg::dev_e      dev_sel_o
   );

  import fabric_pkg::*;

  logic [DEV_MSB-DEV_LSB:0] dev_field;
  core_id_t                 tile_field;
  logic                     is_local;
  logic                     is_my_tile;

  assign dev_field  = req_addr_i[DEV_MSB:DEV_LSB];
  assign tile_field = req_addr_i[TILE_MSB:TILE_LSB];

  // Local space sits below the DRAM base
  assign is_local   = (req_addr_i < DRAM_BASE);
  assign is_my_tile = is_local && (tile_field == core_id_i);

  always_comb
  begin
    dev_sel_o = DEV_LOOPBACK;
    if (is_my_tile)
    begin
      if (dev_field == DEV_ID_CFG)
      begin
        dev_sel_o = DEV_CFG;
      end
      else if (dev_field == DEV_ID_CLINT)
      begin
        dev_sel_o = DEV_CLINT;
      end
    end
  end

endmodule

//--- src/fabric_ctrl.sv
//################################################
// Round-robin arbiter and serialized transaction FSM
// One command in flight, response two cycles after accept
// Responses hold until the issuing requester takes them
//################################################
`timescale 1ns/100ps

module fabric_ctrl
  (input                                                 clk_i
   , input                                               arst_n_i

   , input        [fabric_pkg::NUM_SRC-1:0]              cmd_v_i
   , output logic [fabric_pkg::NUM_SRC-1:0]              cmd_ready_o
   , input  fabric_pkg::addr_t [fabric_pkg::NUM_SRC-1:0] cmd_addr_i
   , input        [fabric_pkg::NUM_SRC-1:0]              cmd_wr_i
   , input  fabric_pkg::data_t [fabric_pkg::NUM_SRC-1:0] cmd_wdata_i

   , output logic [fabric_pkg::NUM_SRC-1:0]              resp_v_o
   , input        [fabric_pkg::NUM_SRC-1:0]              resp_ready_i
   , output fabric_pkg::data_t [fabric_pkg::NUM_SRC-1:0] resp_rdata_o
   , output logic [fabric_pkg::NUM_SRC-1:0]              resp_err_o

   , output fabric_pkg::addr_t                           req_addr_o
   , input  fabric_pkg::dev_e                            dev_sel_i

   , output fabric_pkg::reg_idx_t                        req_reg_o
   , output logic                                        req_wr_o
   , output fabric_pkg::data_t                           req_wdata_o
   , output logic                                        cfg_v_o
   , output logic                                        clint_v_o
   , input  fabric_pkg::data_t                           cfg_rdata_i
   , input  fabric_pkg::data_t                           clint_rdata_i
   );

  import fabric_pkg::*;

  fabric_state_e state_q;
  src_id_t       ptr_q;
  src_id_t       src_q;
  src_id_t       other_idx;
  src_id_t       grant_idx;
  logic          grant_v;
  addr_t         addr_q;
  logic          wr_q;
  data_t         wdata_q;
  logic          err_q;
  data_t         sel_rdata;

  assign other_idx = ptr_q + 1'b1;

  // Pointer holder first, then the other requester
  always_comb
  begin
    grant_idx = ptr_q;
    grant_v   = 1'b0;
    if (cmd_v_i[ptr_q])
    begin
      grant_v = 1'b1;
    end
    else if (cmd_v_i[other_idx])
    begin
      grant_idx = other_idx;
      grant_v   = 1'b1;
    end
  end

  always_comb
  begin
    cmd_ready_o = '0;
    if ((state_q == ST_IDLE) && grant_v)
    begin
      cmd_ready_o[grant_idx] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_q <= ST_IDLE;
      ptr_q   <= '0;
      src_q   <= '0;
      err_q   <= 1'b0;
    end
    else
    begin
      case (state_q)
        ST_IDLE:
        begin
          if (grant_v)
          begin
            src_q   <= grant_idx;
            ptr_q   <= grant_idx + 1'b1;
            state_q <= ST_ACCESS;
          end
        end
        ST_ACCESS:
        begin
          err_q   <= (dev_sel_i == DEV_LOOPBACK);
          state_q <= ST_RESP;
        end
        ST_RESP:
        begin
          if (resp_ready_i[src_q])
          begin
            state_q <= ST_IDLE;
          end
        end
        default:
        begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // Granted command payload
  always_ff @(posedge clk_i)
  begin
    if ((state_q == ST_IDLE) && grant_v)
    begin
      addr_q  <= cmd_addr_i[grant_idx];
      wr_q    <= cmd_wr_i[grant_idx];
      wdata_q <= cmd_wdata_i[grant_idx];
    end
  end

  assign req_addr_o  = addr_q;
  assign req_reg_o   = addr_q[REG_MSB:REG_LSB];
  assign req_wr_o    = wr_q;
  assign req_wdata_o = wdata_q;

  // Single-cycle strobe to the decoded slice
  assign cfg_v_o   = (state_q == ST_ACCESS) && (dev_sel_i == DEV_CFG);
  assign clint_v_o = (state_q == ST_ACCESS) && (dev_sel_i == DEV_CLINT);

  // Writes and loopback answer zero
  always_comb
  begin
    sel_rdata = '0;
    if (!wr_q && !err_q)
    begin
      case (dev_sel_i)
        DEV_CFG:   sel_rdata = cfg_rdata_i;
        DEV_CLINT: sel_rdata = clint_rdata_i;
        default:   sel_rdata = '0;
      endcase
    end
  end

  always_comb
  begin
    resp_v_o     = '0;
    resp_rdata_o = '0;
    resp_err_o   = '0;
    if (state_q == ST_RESP)
    begin
      resp_v_o[src_q]     = 1'b1;
      resp_rdata_o[src_q] = sel_rdata;
      resp_err_o[src_q]   = err_q;
    end
  end

  // Only one requester accepted, and it is the one answered two cycles later
  a_ready_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $rose(|resp_v_o) |-> (resp_v_o == $past(cmd_v_i & cmd_ready_o, 2)));

  // Slice read data must not move under a stalled response
  a_resp_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    |(resp_v_o & ~resp_ready_i) |=> (resp_v_o == $past(resp_v_o))
      && $stable(resp_rdata_o) && $stable(resp_err_o));

endmodule

//--- src/cfg_slice.sv
//################################################
// Configuration registers: scratch, freeze, core identity
// Identity is sampled from cord_i while reset is held
//################################################
`timescale 1ns/100ps

module cfg_slice
  (input                           clk_i
   , input                         arst_n_i

   , input                         cfg_v_i
   , input  fabric_pkg::reg_idx_t  req_reg_i
   , input                         req_wr_i
   , input  fabric_pkg::data_t     req_wdata_i
   , input  fabric_pkg::core_id_t  cord_i

   , output fabric_pkg::data_t     rdata_o
   , output logic                  freeze_o
   , output fabric_pkg::core_id_t  core_id_o
   );

  import fabric_pkg::*;

  data_t    scratch_q;
  logic     freeze_q;
  core_id_t core_id_q;
  data_t    rdata_q;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      scratch_q <= '0;
      freeze_q  <= 1'b1;
    end
    else if (cfg_v_i && req_wr_i)
    begin
      case (req_reg_i)
        CFG_REG_SCRATCH: scratch_q <= req_wdata_i;
        CFG_REG_FREEZE:  freeze_q  <= req_wdata_i[0];
        default:         ;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!arst_n_i)
    begin
      core_id_q <= cord_i;
    end
  end

  // Read data holds until the next read strobe
  always_ff @(posedge clk_i)
  begin
    if (cfg_v_i && !req_wr_i)
    begin
      case (req_reg_i)
        CFG_REG_SCRATCH: rdata_q <= scratch_q;
        CFG_REG_FREEZE:  rdata_q <= data_t'(freeze_q);
        CFG_REG_CORE_ID: rdata_q <= data_t'(core_id_q);
        default:         rdata_q <= '0;
      endcase
    end
  end

  assign rdata_o   = rdata_q;
  assign freeze_o  = freeze_q;
  assign core_id_o = core_id_q;

endmodule

//--- src/clint_slice.sv
//################################################
// Core-local timer and software interrupt
// mtime runs on clk_i and stops while frozen
//################################################
`timescale 1ns/100ps

module clint_slice
  (input                           clk_i
   , input                         arst_n_i

   , input                         clint_v_i
   , input  fabric_pkg::reg_idx_t  req_reg_i
   , input                         req_wr_i
   , input  fabric_pkg::data_t     req_wdata_i
   , input                         freeze_i

   , output fabric_pkg::data_t     rdata_o
   , output logic                  timer_irq_o
   , output logic                  software_irq_o
   );

  import fabric_pkg::*;

  data_t mtime_q;
  data_t mtimecmp_q;
  logic  msip_q;
  logic  timer_irq_q;
  data_t rdata_q;
  logic  wr_en;

  assign wr_en = clint_v_i && req_wr_i;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      mtime_q     <= '0;
      mtimecmp_q  <= '1;
      msip_q      <= 1'b0;
      timer_irq_q <= 1'b0;
    end
    else
    begin
      // A write to mtime wins over the count
      if (wr_en && (req_reg_i == CLINT_REG_MTIME))
      begin
        mtime_q <= req_wdata_i;
      end
      else if (!freeze_i)
      begin
        mtime_q <= mtime_q + 64'd1;
      end
      if (wr_en && (req_reg_i == CLINT_REG_MTIMECMP))
      begin
        mtimecmp_q <= req_wdata_i;
      end
      if (wr_en && (req_reg_i == CLINT_REG_MSIP))
      begin
        msip_q <= req_wdata_i[0];
      end
      timer_irq_q <= (mtime_q >= mtimecmp_q);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (clint_v_i && !req_wr_i)
    begin
      case (req_reg_i)
        CLINT_REG_MTIME:    rdata_q <= mtime_q;
        CLINT_REG_MTIMECMP: rdata_q <= mtimecmp_q;
        CLINT_REG_MSIP:     rdata_q <= data_t'(msip_q);
        default:            rdata_q <= '0;
      endcase
    end
  end

  assign rdata_o        = rdata_q;
  assign timer_irq_o    = timer_irq_q;
  assign software_irq_o = msip_q;

  // Compare is registered, so look one cycle back
  a_no_irq_at_max_cmp: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (&mtimecmp_q) && $past(&mtimecmp_q) |-> !timer_irq_o);

endmodule

//--- src/unicore_fabric.sv
//################################################
// Command fabric top: two requesters, cfg, clint, loopback
// Serialized, one transaction open at a time
//################################################
`timescale 1ns/100ps

module unicore_fabric
  (input                                                 clk_i
   , input                                               arst_n_i
   , input  fabric_pkg::core_id_t                        cord_i

   , input        [fabric_pkg::NUM_SRC-1:0]              cmd_v_i
   , output logic [fabric_pkg::NUM_SRC-1:0]              cmd_ready_o
   , input  fabric_pkg::addr_t [fabric_pkg::NUM_SRC-1:0] cmd_addr_i
   , input        [fabric_pkg::NUM_SRC-1:0]              cmd_wr_i
   , input  fabric_pkg::data_t [fabric_pkg::NUM_SRC-1:0] cmd_wdata_i

   , output logic [fabric_pkg::NUM_SRC-1:0]              resp_v_o
   , input        [fabric_pkg::NUM_SRC-1:0]              resp_ready_i
   , output fabric_pkg::data_t [fabric_pkg::NUM_SRC-1:0] resp_rdata_o
   , output logic [fabric_pkg::NUM_SRC-1:0]              resp_err_o

   , output logic                                        timer_irq_o
   , output logic                                        software_irq_o
   , output logic                                        freeze_o
   );

  import fabric_pkg::*;

  addr_t    req_addr;
  dev_e     dev_sel;
  core_id_t core_id;
  reg_idx_t req_reg;
  logic     req_wr;
  data_t    req_wdata;
  logic     cfg_v;
  logic     clint_v;
  data_t    cfg_rdata;
  data_t    clint_rdata;

  fabric_ctrl ctrl
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.cmd_v_i(cmd_v_i)
     ,.cmd_ready_o(cmd_ready_o)
     ,.cmd_addr_i(cmd_addr_i)
     ,.cmd_wr_i(cmd_wr_i)
     ,.cmd_wdata_i(cmd_wdata_i)
     ,.resp_v_o(resp_v_o)
     ,.resp_ready_i(resp_ready_i)
     ,.resp_rdata_o(resp_rdata_o)
     ,.resp_err_o(resp_err_o)
     ,.req_addr_o(req_addr)
     ,.dev_sel_i(dev_sel)
     ,.req_reg_o(req_reg)
     ,.req_wr_o(req_wr)
     ,.req_wdata_o(req_wdata)
     ,.cfg_v_o(cfg_v)
     ,.clint_v_o(clint_v)
     ,.cfg_rdata_i(cfg_rdata)
     ,.clint_rdata_i(clint_rdata)
     );

  dev_decode decode
    (.req_addr_i(req_addr)
     ,.core_id_i(core_id)
     ,.dev_sel_o(dev_sel)
     );

  cfg_slice cfgs
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.cfg_v_i(cfg_v)
     ,.req_reg_i(req_reg)
     ,.req_wr_i(req_wr)
     ,.req_wdata_i(req_wdata)
     ,.cord_i(cord_i)
     ,.rdata_o(cfg_rdata)
     ,.freeze_o(freeze_o)
     ,.core_id_o(core_id)
     );

  // Freeze from cfg also stops the time counter
  clint_slice clints
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.clint_v_i(clint_v)
     ,.req_reg_i(req_reg)
     ,.req_wr_i(req_wr)
     ,.req_wdata_i(req_wdata)
     ,.freeze_i(freeze_o)
     ,.rdata_o(clint_rdata)
     ,.timer_irq_o(timer_irq_o)
     ,.software_irq_o(software_irq_o)
     );

endmodule

//--- tb/tb_unicore_fabric.sv
//################################################
// Testbench for the command fabric at tile 5
// Reads tb/fabric_stimulus.txt, so it runs from the project root
//################################################
`timescale 1ns/100ps

module tb_unicore_fabric;

  localparam int COLS      = 7;
  localparam int MAX_LINES = 64;
  localparam int IRQ_LIMIT = 10;

  // Check kinds in the second stimulus column
  localparam int K_MTIME   = 1;
  localparam int K_TIRQ_HI = 2;
  localparam int K_TIRQ_LO = 3;
  localparam int K_SIRQ_HI = 4;
  localparam int K_SIRQ_LO = 5;

  // Freeze register of tile 5
  localparam logic [31:0] FREEZE_ADDR = 32'h0148_0008;

  logic             clk;
  logic             arst_n;
  logic [1:0]       cmd_v;
  logic [1:0]       cmd_ready;
  logic [1:0][31:0] cmd_addr;
  logic [1:0]       cmd_wr;
  logic [1:0][63:0] cmd_wdata;
  logic [1:0]       resp_v;
  logic [1:0]       resp_ready;
  logic [1:0][63:0] resp_rdata;
  logic [1:0]       resp_err;
  logic             timer_irq;
  logic             software_irq;
  logic             freeze;

  logic [63:0] stim_mem [0:COLS*MAX_LINES-1];
  int          cmd_q [0:1][$];
  int          exp_q [0:1][$];
  logic [1:0]  drop_v;
  logic [1:0]  held_v;
  logic [63:0] held_data [0:1];
  logic [63:0] last_mtime;
  logic        exp_freeze;
  int          n_lines;
  int          irq_wait;
  int          irq_cnt;
  int          error_count;
  int          checked;
  logic        load_done;

  unicore_fabric unicore_fabric_inst
    (.clk_i(clk)
     ,.arst_n_i(arst_n)
     ,.cord_i(8'h05)
     ,.cmd_v_i(cmd_v)
     ,.cmd_ready_o(cmd_ready)
     ,.cmd_addr_i(cmd_addr)
     ,.cmd_wr_i(cmd_wr)
     ,.cmd_wdata_i(cmd_wdata)
     ,.resp_v_o(resp_v)
     ,.resp_ready_i(resp_ready)
     ,.resp_rdata_o(resp_rdata)
     ,.resp_err_o(resp_err)
     ,.timer_irq_o(timer_irq)
     ,.software_irq_o(software_irq)
     ,.freeze_o(freeze)
     );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #10 clk = ~clk;
    end
  end

  // Last line of the file holds f in the requester column
  task automatic load_stimulus();
    int   i;
    logic found;
    $readmemh("tb/fabric_stimulus.txt", stim_mem);
    i = 0;
    found = 1'b0;
    while (!found && (i < MAX_LINES))
    begin
      if (stim_mem[i*COLS] == 64'hf)
      begin
        found = 1'b1;
      end
      else
      begin
        cmd_q[stim_mem[i*COLS][0]].push_back(i);
        i++;
      end
    end
    n_lines = found ? i : 0;
  endtask

  task automatic drive_requester(input logic sid);
    int b;
    if (drop_v[sid])
    begin
      cmd_v[sid]  = 1'b0;
      drop_v[sid] = 1'b0;
    end
    // One open command per requester, with random idle gaps
    if (!cmd_v[sid] && (cmd_q[sid].size() > 0) && (exp_q[sid].size() == 0))
    begin
      if ((irq_wait == 0) && (($urandom % 3) != 0))
      begin
        b = cmd_q[sid][0] * COLS;
        cmd_v[sid]     = 1'b1;
        cmd_wr[sid]    = stim_mem[b+2][0];
        cmd_addr[sid]  = stim_mem[b+3][31:0];
        cmd_wdata[sid] = stim_mem[b+4];
      end
    end
    resp_ready[sid] = (($urandom % 4) != 0);
  endtask

  task automatic check_response(input logic sid);
    int          idx;
    int          kind;
    logic [63:0] exp_data;
    logic        exp_err;
    if (exp_q[sid].size() == 0)
    begin
      $display("Requester %0d got a response with no command open", sid);
      error_count++;
    end
    else
    begin
      idx      = exp_q[sid].pop_front();
      kind     = int'(stim_mem[idx*COLS+1][3:0]);
      exp_data = stim_mem[idx*COLS+5];
      exp_err  = stim_mem[idx*COLS+6][0];
      checked++;
      // Bit 0 of a freeze write sets freeze_o
      if (stim_mem[idx*COLS+2][0] && (stim_mem[idx*COLS+3][31:0] == FREEZE_ADDR))
      begin
        exp_freeze = stim_mem[idx*COLS+4][0];
      end
      if (freeze != exp_freeze)
      begin
        $display("ERROR %0t: line %0d freeze_o is %b, expected %b", $time, idx,
                 freeze, exp_freeze);
        error_count++;
      end
      if (kind == K_MTIME)
      begin
        if (resp_err[sid] || (resp_rdata[sid] <= last_mtime))
        begin
          $display("ERROR %0t: line %0d mtime %h after %h, err %b", $time, idx,
                   resp_rdata[sid], last_mtime, resp_err[sid]);
          error_count++;
        end
        last_mtime = resp_rdata[sid];
      end
      else if ((resp_rdata[sid] != exp_data) || (resp_err[sid] != exp_err))
      begin
        $display("ERROR %0t: line %0d requester %0d got %h err %b, expected %h err %b",
                 $time, idx, sid, resp_rdata[sid], resp_err[sid], exp_data, exp_err);
        error_count++;
      end
      if ((kind == K_TIRQ_HI) || (kind == K_TIRQ_LO))
      begin
        irq_wait = kind;
        irq_cnt  = 0;
      end
      if (((kind == K_SIRQ_HI) && !software_irq) || ((kind == K_SIRQ_LO) && software_irq))
      begin
        $display("ERROR %0t: line %0d software_irq_o is %b", $time, idx, software_irq);
        error_count++;
      end
    end
  endtask

  task automatic observe_requester(input logic sid);
    int idx;
    if (cmd_v[sid] && cmd_ready[sid])
    begin
      idx = cmd_q[sid].pop_front();
      exp_q[sid].push_back(idx);
      drop_v[sid] = 1'b1;
    end
    if (held_v[sid] && (!resp_v[sid] || (resp_rdata[sid] != held_data[sid])))
    begin
      $display("ERROR %0t: requester %0d response moved while stalled", $time, sid);
      error_count++;
    end
    held_v[sid]    = resp_v[sid] && !resp_ready[sid];
    held_data[sid] = resp_rdata[sid];
    if (resp_v[sid] && resp_ready[sid])
    begin
      check_response(sid);
    end
  endtask

  task automatic track_timer_irq();
    if (irq_wait != 0)
    begin
      if (timer_irq == (irq_wait == K_TIRQ_HI))
      begin
        irq_wait = 0;
      end
      else
      begin
        irq_cnt++;
        if (irq_cnt >= IRQ_LIMIT)
        begin
          $display("ERROR %0t: timer_irq_o stuck at %b", $time, timer_irq);
          error_count++;
          irq_wait = 0;
        end
      end
    end
  endtask

  function automatic bit all_done();
    return (cmd_q[0].size() == 0) && (cmd_q[1].size() == 0) && (exp_q[0].size() == 0)
           && (exp_q[1].size() == 0) && (irq_wait == 0);
  endfunction

  initial
  begin
    arst_n      = 1'b0;
    cmd_v       = '0;
    cmd_addr    = '0;
    cmd_wr      = '0;
    cmd_wdata   = '0;
    resp_ready  = '0;
    drop_v      = '0;
    held_v      = '0;
    last_mtime  = '0;
    exp_freeze  = 1'b1;
    irq_wait    = 0;
    irq_cnt     = 0;
    error_count = 0;
    checked     = 0;
    load_done   = 1'b0;
    void'($urandom(32'he6c5_4029));
    load_stimulus();
    load_done = 1'b1;
    repeat (8) @(negedge clk);
    arst_n = 1'b1;
    if (n_lines == 0)
    begin
      $display("Stimulus file has no end marker within %0d lines", MAX_LINES);
      error_count++;
    end
    else
    begin
      while (!all_done())
      begin
        @(negedge clk);
        drive_requester(1'b0);
        drive_requester(1'b1);
        #1;
        if ((|resp_v) && (|cmd_ready))
        begin
          $display("ERROR %0t: cmd_ready_o %b while a response is open", $time, cmd_ready);
          error_count++;
        end
        track_timer_irq();
        observe_requester(1'b0);
        observe_requester(1'b1);
      end
    end
    $display("Responses checked: %0d, errors: %0d", checked, error_count);
    if (error_count == 0)
    begin
      $display("Simulation finished: PASS");
    end
    else
    begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial
  begin
    wait (load_done);
    repeat (200 * n_lines + 20) @(posedge clk);
    $display("Timeout: the commands did not complete within the cycle limit");
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

//--- tb/fabric_stimulus.txt
// Columns: requester, kind, write, address, write data, expected data, expected error
// Kind: 0 exact, 1 mtime rising, 2 timer irq high, 3 timer irq low, 4 sw irq high, 5 sw irq low
0 0 1 01480000 0123456789abcdef 0 0
0 0 0 01480000 0 0123456789abcdef 0
0 0 0 01480010 0 5 0
0 0 1 01480000 a5a5a5a55a5a5a5a 0 0
0 0 0 01480000 0 a5a5a5a55a5a5a5a 0
0 0 1 01480008 0 0 0
0 1 0 01440000 0 0 0
0 1 0 01440000 0 0 0
0 2 1 01440008 0 0 0
0 3 1 01440008 ffffffffffffffff 0 0
0 0 0 01440008 0 ffffffffffffffff 0
0 4 1 01440010 1 0 0
0 0 0 01440010 0 1 0
0 5 1 01440010 0 0 0
0 0 0 80000000 0 0 1
1 0 0 01480010 0 5 0
1 0 0 80000000 0 0 1
1 0 1 ffffffc0 1234 0 1
1 0 0 01880000 0 0 1
1 0 0 014c0000 0 0 1
1 0 0 01400000 0 0 1
1 0 1 01480020 dead 0 0
1 0 0 01480020 0 0 0
1 0 0 01480018 0 0 0
1 0 0 01480010 0 5 0
f 0 0 0 0 0 0

//--- src.f
src/fabric_pkg.sv
src/dev_decode.sv
src/fabric_ctrl.sv
src/cfg_slice.sv
src/clint_slice.sv
src/unicore_fabric.sv
tb/tb_unicore_fabric.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and judge the result from the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module tb_unicore_fabric -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
  exit 1
fi
if ! grep -q "Simulation finished: PASS" "$LOG"; then
  echo "No result line found in $LOG"
  exit 1
fi
exit 0
